// File: list.f
+incdir+src
src/decode_pkg.sv
src/opclass_stage.sv
src/control_stage.sv
src/decode_top.sv
sim/tb_clock.sv
sim/decode_checker.sv
sim/decode_tb.sv

// File: run.sh
#!/bin/bash
# build and run the decoder testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module decode_tb -Mdir obj_dir &&
./obj_dir/Vdecode_tb | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: sim/decode_tb.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_tb
    import decode_pkg::*;
();

    localparam int N_IDLE   = 5;
    localparam int N_RANDOM = 200;
    localparam int N_DRAIN  = 4;
    // alu forms x funct3 x funct7, then every load and store funct3
    localparam int N_EDGE   = 4 * 3 * 5 + 8 * 2;
    // stimulus cycles of all tests with their drains
    localparam int RUN_CYCLES = N_IDLE + 1 + 3 * N_RANDOM + N_EDGE + 5 * N_DRAIN;

    logic clk, reset_i, inst_valid_i;
    logic [`INST_W-1:0] inst_i;
    logic ctrl_valid_o, rs1_en_o, rs2_en_o, rd_en_o, jump_base_pc_o, inst_jump_o;
    logic inst_branch_o, inst_lui_o, inst_auipc_o, inst_word_o, inst_shift_o;
    logic inst_slt_o, inst_sltu_o, inst_arith_o, alu_src_pc_o, alu_src_imm_o;
    logic shift_imm_o, mem_read_o, mem_write_o;
    gen_type_e gen_type_o;
    alu_op_e alu_op_o;
    comp_type_e comp_type_o;
    shift_type_e shift_type_o;
    load_type_e load_type_o;
    store_type_e store_type_o;
    logic [35:0] ctrl_bus;
    int sent = 0;
    int tb_errors = 0;
    int last_errors = 0;
    logic [4:0] opcs [11] = '{`EOPC_LUI, `EOPC_AUIPC, `EOPC_JAL, `EOPC_JALR,
        `EOPC_BRANCH, `EOPC_LOAD, `EOPC_STORE, `EOPC_ALI, `EOPC_ALIW, `EOPC_AL, `EOPC_ALW};
    logic [6:0] f7s [5] = '{7'h00, 7'h20, 7'h01, 7'h21, 7'h40};
    logic [2:0] f3s [3] = '{3'd0, 3'd1, 3'd5};

    tb_clock clk0 (.clk(clk), .reset_i(reset_i));

    decode_top dut0 (.*);

    assign ctrl_bus = {rs1_en_o, rs2_en_o, rd_en_o, jump_base_pc_o, inst_jump_o,
        inst_branch_o, inst_lui_o, inst_auipc_o, inst_word_o, inst_shift_o, inst_slt_o,
        inst_sltu_o, inst_arith_o, alu_src_pc_o, alu_src_imm_o, shift_imm_o, mem_read_o,
        mem_write_o, gen_type_o, alu_op_o, comp_type_o, shift_type_o, load_type_o,
        store_type_o};

    decode_checker chk0 (.clk(clk), .reset_i(reset_i), .inst_valid_i(inst_valid_i),
        .inst_i(inst_i), .ctrl_valid_i(ctrl_valid_o), .actual_i(ctrl_bus));

    task automatic send(input logic v, input logic [31:0] w);
        @(negedge clk);
        inst_valid_i = v;
        inst_i = w;
        if (v) sent++;
    endtask

    // legal class with funct7 biased toward the values the decoder checks
    function automatic logic [31:0] legal_inst();
        logic [31:0] r;
        logic [6:0] f7;
        r = $urandom;
        f7 = (r[31:30] == 2'd3) ? 7'($urandom) : f7s[r[29:28]];
        return {f7, r[17:0], opcs[$urandom_range(10)], 2'b11};
    endfunction

    task automatic finish_test(input string name);
        repeat (N_DRAIN) send(1'b0, 32'h0);
        $display("test %s done, %0d errors", name, chk0.errors + tb_errors - last_errors);
        last_errors = chk0.errors + tb_errors;
    endtask

    initial begin
        #((RUN_CYCLES + 8 + 50) * 20);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        inst_valid_i = 1'b0;
        inst_i = '0;
        void'($urandom(84792));
        @(negedge reset_i);
        // idle pipe must stay quiet
        repeat (N_IDLE) begin
            send(1'b0, 32'h0);
            if (ctrl_valid_o !== 1'b0) begin
                tb_errors++;
                $display("Error: ctrl_valid_o expected 0 actual %h", ctrl_valid_o);
            end
        end
        send(1'b1, 32'h00000033);
        finish_test("reset");
        repeat (N_RANDOM) send(1'b1, legal_inst());
        finish_test("legal");
        repeat (N_RANDOM) send(1'b1, $urandom);
        finish_test("random words");
        for (int c = 7; c < 11; c++)
            for (int a = 0; a < 3; a++)
                for (int b = 0; b < 5; b++)
                    send(1'b1, {f7s[b], 5'h0a, 5'h05, f3s[a], 5'h03, opcs[c], 2'b11});
        for (int a = 0; a < 8; a++) begin
            send(1'b1, {17'h1234, 3'(a), 5'h01, `EOPC_LOAD, 2'b11});
            send(1'b1, {17'h0567, 3'(a), 5'h02, `EOPC_STORE, 2'b11});
        end
        finish_test("edge encodings");
        repeat (N_RANDOM) send(1'($urandom), legal_inst());
        finish_test("bubbles");
        if (chk0.pulses != sent) begin
            tb_errors++;
            $display("%0d instructions sent but %0d ctrl_valid_o pulses", sent, chk0.pulses);
        end
        $display("tests 5, instructions %0d, errors %0d", sent, chk0.errors + tb_errors);
        if (chk0.errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim/decode_checker.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_checker (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               inst_valid_i,
    input  logic [`INST_W-1:0] inst_i,
    input  logic               ctrl_valid_i,
    input  logic [35:0]        actual_i
);

    int errors = 0;
    int pulses = 0;
    int cycle  = 0;
    logic [35:0] exp_q[$];
    int          stamp_q[$];

    // field order matches the packed output bus, msb first
    string names [24] = '{"rs1_en_o", "rs2_en_o", "rd_en_o", "jump_base_pc_o",
        "inst_jump_o", "inst_branch_o", "inst_lui_o", "inst_auipc_o", "inst_word_o",
        "inst_shift_o", "inst_slt_o", "inst_sltu_o", "inst_arith_o", "alu_src_pc_o",
        "alu_src_imm_o", "shift_imm_o", "mem_read_o", "mem_write_o", "gen_type_o",
        "alu_op_o", "comp_type_o", "shift_type_o", "load_type_o", "store_type_o"};

    // reference model built from the decode rules
    function automatic logic [35:0] model(input logic [31:0] w);
        logic [4:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic lui, auipc, jal, jalr, br, ld, st, ali, aliw, al, alw;
        logic alu, imm, sh, f7z, f7a, hz, ha, rz, slt, sltu;
        logic [2:0] gen, aop, cmp, sht, ldt, stt;
        opc = w[6:2];
        f3 = w[14:12];
        f7 = w[31:25];
        lui = opc == `EOPC_LUI;
        auipc = opc == `EOPC_AUIPC;
        jal = opc == `EOPC_JAL;
        jalr = opc == `EOPC_JALR;
        br = opc == `EOPC_BRANCH;
        ld = opc == `EOPC_LOAD;
        st = opc == `EOPC_STORE;
        ali = opc == `EOPC_ALI;
        aliw = opc == `EOPC_ALIW;
        al = opc == `EOPC_AL;
        alw = opc == `EOPC_ALW;
        alu = ali | aliw | al | alw;
        imm = ali | aliw;
        sh = alu & (f3[1:0] == 2'b01);
        f7z = f7 == 7'h00;
        f7a = f7 == 7'h20;
        hz = f7[6:1] == 6'h00;
        ha = f7[6:1] == 6'h10;
        // full-width ops: addi/xori etc. or register form with funct7 zero
        rz = ali | (al & f7z);
        slt = rz & (f3 == 3'd2);
        sltu = rz & (f3 == 3'd3);
        gen = st ? 3'd3 : (lui | auipc) ? 3'd4 : jal ? 3'd5
            : (jalr | ld | (imm & ~sh)) ? 3'd6 : br ? 3'd7 : 3'd0;
        aop = 3'd0;
        if (auipc | jal | jalr | ld | st) aop = 3'd3;
        else if ((imm | ((al | alw) & f7z)) & (f3 == 3'd0)) aop = 3'd3;
        else if ((al | alw) & f7a & (f3 == 3'd0)) aop = 3'd4;
        else if (slt | sltu) aop = 3'd4;
        else if (rz & (f3 == 3'd4)) aop = 3'd5;
        else if (rz & (f3 == 3'd6)) aop = 3'd6;
        else if (rz & (f3 == 3'd7)) aop = 3'd7;
        cmp = slt ? 3'd4 : sltu ? 3'd5 : 3'd0;
        if (br) begin
            case (f3)
                3'd0: cmp = 3'd2;
                3'd1: cmp = 3'd3;
                3'd4: cmp = 3'd4;
                3'd6: cmp = 3'd5;
                3'd5: cmp = 3'd6;
                3'd7: cmp = 3'd7;
                default: cmp = 3'd0;
            endcase
        end
        sht = 3'd0;
        if (f3 == 3'd1 && (al & f7z | ali & hz)) sht = 3'd1;
        else if (f3 == 3'd1 && ((alw | aliw) & f7z)) sht = 3'd3;
        else if (f3 == 3'd5 && (al & f7z | ali & hz)) sht = 3'd5;
        else if (f3 == 3'd5 && (al & f7a | ali & ha)) sht = 3'd4;
        else if (f3 == 3'd5 && ((alw | aliw) & f7z)) sht = 3'd7;
        else if (f3 == 3'd5 && ((alw | aliw) & f7a)) sht = 3'd6;
        ldt = (ld && f3 != 3'd7) ? 3'(f3 + 3'd1) : 3'd0;
        stt = (st && f3 < 3'd4) ? 3'(f3 + 3'd4) : 3'd0;
        return {jalr | br | ld | st | alu, br | st | al | alw,
                lui | auipc | jal | jalr | ld | alu, jalr, jal | jalr, br, lui, auipc,
                aliw | alw, sh, slt, sltu, alu, ~auipc, auipc | ld | st | (imm & ~sh),
                sh & imm, ld, st, gen, aop, cmp, sht, ldt, stt};
    endfunction

    task automatic compare(input logic [35:0] exp, input logic [35:0] act);
        int lo;
        int w;
        logic [35:0] mask;
        for (int i = 0; i < 24; i++) begin
            w = (i < 18) ? 1 : 3;
            lo = (i < 18) ? 35 - i : 15 - 3 * (i - 18);
            mask = (36'd1 << w) - 36'd1;
            if (((exp >> lo) & mask) != ((act >> lo) & mask)) begin
                errors++;
                $display("Error: %s expected %h actual %h", names[i],
                         (exp >> lo) & mask, (act >> lo) & mask);
            end
        end
    endtask

    // inputs are stable at the rising edge, driven on the falling one
    always @(posedge clk) begin
        if (reset_i) begin
            exp_q.delete();
            stamp_q.delete();
        end else if (inst_valid_i) begin
            exp_q.push_back(model(inst_i));
            stamp_q.push_back(cycle);
        end
        cycle = cycle + 1;
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!reset_i && ctrl_valid_i) begin
            pulses++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ctrl_valid_o went high with no instruction in flight");
            end else begin
                if (cycle - stamp_q[0] != 2) begin
                    errors++;
                    $display("decoded output arrived %0d cycles after input, not 2",
                             cycle - stamp_q[0]);
                end
                compare(exp_q.pop_front(), actual_i);
                void'(stamp_q.pop_front());
            end
        end else if (!reset_i && exp_q.size() != 0 && cycle - stamp_q[0] >= 2) begin
            errors++;
            $display("expected decoded output never appeared");
            void'(exp_q.pop_front());
            void'(stamp_q.pop_front());
        end
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset_i
);

    initial clk = 1'b0;

    // 20 ns period
    always #10 clk = ~clk;

    // hold reset for 8 cycles, release away from the rising edge
    initial begin
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    end

endmodule

// File: src/decode_top.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_top
    import decode_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               inst_valid_i,
    input  logic [`INST_W-1:0] inst_i,

    output logic               ctrl_valid_o,
    output logic               rs1_en_o,
    output logic               rs2_en_o,
    output logic               rd_en_o,
    output logic               jump_base_pc_o,
    output logic               inst_jump_o,
    output logic               inst_branch_o,
    output logic               inst_lui_o,
    output logic               inst_auipc_o,
    output logic               inst_word_o,
    output logic               inst_shift_o,
    output logic               inst_slt_o,
    output logic               inst_sltu_o,
    output logic               inst_arith_o,
    output logic               alu_src_pc_o,
    output logic               alu_src_imm_o,
    output logic               shift_imm_o,
    output logic               mem_read_o,
    output logic               mem_write_o,
    output gen_type_e          gen_type_o,
    output alu_op_e            alu_op_o,
    output comp_type_e         comp_type_o,
    output shift_type_e        shift_type_o,
    output load_type_e         load_type_o,
    output store_type_e        store_type_o
);

    // stage 1 to stage 2
    opclass_e   cls;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       cls_valid;

    opclass_stage u_opclass (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .cls_o        (cls),
        .funct3_o     (funct3),
        .funct7_o     (funct7),
        .cls_valid_o  (cls_valid)
    );

    // outputs share their names with the top ports
    control_stage u_control (
        .cls_i       (cls),
        .funct3_i    (funct3),
        .funct7_i    (funct7),
        .cls_valid_i (cls_valid),
        .*
    );

endmodule

// File: src/control_stage.sv
`timescale 1ns/1ps

module control_stage
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,

    // from the class stage
    input  opclass_e    cls_i,
    input  logic [2:0]  funct3_i,
    input  logic [6:0]  funct7_i,
    input  logic        cls_valid_i,

    output logic        ctrl_valid_o,

    // register file and flow control
    output logic        rs1_en_o,
    output logic        rs2_en_o,
    output logic        rd_en_o,
    output logic        jump_base_pc_o,
    output logic        inst_jump_o,
    output logic        inst_branch_o,
    output logic        inst_lui_o,
    output logic        inst_auipc_o,

    // execute
    output logic        inst_word_o,
    output logic        inst_shift_o,
    output logic        inst_slt_o,
    output logic        inst_sltu_o,
    output logic        inst_arith_o,
    output logic        alu_src_pc_o,
    output logic        alu_src_imm_o,
    output logic        shift_imm_o,

    // memory
    output logic        mem_read_o,
    output logic        mem_write_o,

    // encoded fields
    output gen_type_e   gen_type_o,
    output alu_op_e     alu_op_o,
    output comp_type_e  comp_type_o,
    output shift_type_e shift_type_o,
    output load_type_e  load_type_o,
    output store_type_e store_type_o
);

    logic is_ali;
    logic is_aliw;
    logic is_al;
    logic is_alw;
    logic alu_cls;
    logic imm_alu;
    logic shift;
    logic f7_zero;
    logic f7_alt;
    logic f7h_zero;
    logic f7h_alt;
    logic slt_any;
    logic sltu_any;

    gen_type_e   gen_type;
    alu_op_e     alu_op;
    comp_type_e  comp_type;
    shift_type_e shift_type;
    load_type_e  load_type;
    store_type_e store_type;

    assign is_ali  = (cls_i == ALI);
    assign is_aliw = (cls_i == ALIW);
    assign is_al   = (cls_i == AL);
    assign is_alw  = (cls_i == ALW);
    assign alu_cls = is_ali | is_aliw | is_al | is_alw;
    assign imm_alu = is_ali | is_aliw;
    assign shift   = alu_cls & (funct3_i[1:0] == 2'b01);

    // funct7 patterns, 64-bit imm shifts give up bit 25 to shamt
    assign f7_zero  = (funct7_i == 7'b0000000);
    assign f7_alt   = (funct7_i == 7'b0100000);
    assign f7h_zero = (funct7_i[6:1] == 6'b000000);
    assign f7h_alt  = (funct7_i[6:1] == 6'b010000);

    assign slt_any  = (is_al & f7_zero | is_ali) & (funct3_i == 3'b010);
    assign sltu_any = (is_al & f7_zero | is_ali) & (funct3_i == 3'b011);

    // immediate format
    always_comb begin
        case (cls_i)
            STORE:       gen_type = GEN_S;
            LUI, AUIPC:  gen_type = GEN_U;
            JAL:         gen_type = GEN_J;
            JALR, LOAD:  gen_type = GEN_I;
            BRANCH:      gen_type = GEN_B;
            ALI, ALIW:   gen_type = shift ? GEN_NONE : GEN_I;
            default:     gen_type = GEN_NONE;
        endcase
    end

    // alu operation
    always_comb begin
        alu_op = ALU_NONE;
        case (cls_i)
            AUIPC, JAL, JALR, LOAD, STORE: begin
                alu_op = ALU_ADD;
            end
            ALI, ALIW, AL, ALW: begin
                // imm forms ignore funct7, register forms need an exact match
                if (imm_alu || f7_zero) begin
                    case (funct3_i)
                        3'b000:         alu_op = ALU_ADD;
                        3'b010, 3'b011: alu_op = (is_aliw || is_alw) ? ALU_NONE : ALU_SUB;
                        3'b100:         alu_op = (is_ali || is_al) ? ALU_XOR : ALU_NONE;
                        3'b110:         alu_op = (is_ali || is_al) ? ALU_OR : ALU_NONE;
                        3'b111:         alu_op = (is_ali || is_al) ? ALU_AND : ALU_NONE;
                        default:        alu_op = ALU_NONE;
                    endcase
                end else if ((is_al || is_alw) && f7_alt && funct3_i == 3'b000) begin
                    alu_op = ALU_SUB;
                end
            end
            default: begin
                alu_op = ALU_NONE;
            end
        endcase
    end

    // compare mode
    always_comb begin
        comp_type = CMP_NONE;
        if (cls_i == BRANCH) begin
            case (funct3_i)
                3'b000:  comp_type = CMP_EQ;
                3'b001:  comp_type = CMP_NE;
                3'b100:  comp_type = CMP_LT;
                3'b110:  comp_type = CMP_LTU;
                3'b101:  comp_type = CMP_GE;
                3'b111:  comp_type = CMP_GEU;
                default: comp_type = CMP_NONE;
            endcase
        end else if (slt_any) begin
            comp_type = CMP_LT;
        end else if (sltu_any) begin
            comp_type = CMP_LTU;
        end
    end

    // shift mode
    always_comb begin
        shift_type = SH_NONE;
        if (funct3_i == 3'b001) begin
            if (is_al && f7_zero || is_ali && f7h_zero) begin
                shift_type = SH_SLL;
            end else if ((is_alw || is_aliw) && f7_zero) begin
                shift_type = SH_SLLW;
            end
        end else if (funct3_i == 3'b101) begin
            if (is_al && f7_zero || is_ali && f7h_zero) begin
                shift_type = SH_SRL;
            end else if (is_al && f7_alt || is_ali && f7h_alt) begin
                shift_type = SH_SRA;
            end else if ((is_alw || is_aliw) && f7_zero) begin
                shift_type = SH_SRLW;
            end else if ((is_alw || is_aliw) && f7_alt) begin
                shift_type = SH_SRAW;
            end
        end
    end

    // memory access width
    always_comb begin
        load_type  = LD_NONE;
        store_type = ST_NONE;
        if (cls_i == LOAD) begin
            case (funct3_i)
                3'b000:  load_type = LD_B;
                3'b001:  load_type = LD_H;
                3'b010:  load_type = LD_W;
                3'b011:  load_type = LD_D;
                3'b100:  load_type = LD_BU;
                3'b101:  load_type = LD_HU;
                3'b110:  load_type = LD_WU;
                default: load_type = LD_NONE;
            endcase
        end
        if (cls_i == STORE) begin
            case (funct3_i)
                3'b000:  store_type = ST_B;
                3'b001:  store_type = ST_H;
                3'b010:  store_type = ST_W;
                3'b011:  store_type = ST_D;
                default: store_type = ST_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_valid_o <= 1'b0;
        end else begin
            ctrl_valid_o <= cls_valid_i;
        end
    end

    // output register, loads only with a valid class
    always_ff @(posedge clk) begin
        if (cls_valid_i) begin
            rs1_en_o       <= (cls_i == JALR) | (cls_i == BRANCH) | (cls_i == LOAD)
                              | (cls_i == STORE) | alu_cls;
            rs2_en_o       <= (cls_i == BRANCH) | (cls_i == STORE) | is_al | is_alw;
            rd_en_o        <= (cls_i == LUI) | (cls_i == AUIPC) | (cls_i == JAL)
                              | (cls_i == JALR) | (cls_i == LOAD) | alu_cls;
            jump_base_pc_o <= (cls_i == JALR);
            inst_jump_o    <= (cls_i == JAL) | (cls_i == JALR);
            inst_branch_o  <= (cls_i == BRANCH);
            inst_lui_o     <= (cls_i == LUI);
            inst_auipc_o   <= (cls_i == AUIPC);
            inst_word_o    <= is_aliw | is_alw;
            inst_shift_o   <= shift;
            inst_slt_o     <= slt_any;
            inst_sltu_o    <= sltu_any;
            inst_arith_o   <= alu_cls;
            alu_src_pc_o   <= (cls_i != AUIPC);
            alu_src_imm_o  <= (cls_i == AUIPC) | (cls_i == LOAD) | (cls_i == STORE)
                              | (imm_alu & ~shift);
            shift_imm_o    <= shift & imm_alu;
            mem_read_o     <= (cls_i == LOAD);
            mem_write_o    <= (cls_i == STORE);
            gen_type_o     <= gen_type;
            alu_op_o       <= alu_op;
            comp_type_o    <= comp_type;
            shift_type_o   <= shift_type;
            load_type_o    <= load_type;
            store_type_o   <= store_type;
        end
    end

endmodule

// File: src/opclass_stage.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module opclass_stage
    import decode_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,

    // raw instruction from fetch
    input  logic               inst_valid_i,
    input  logic [`INST_W-1:0] inst_i,

    // registered class and funct fields
    output opclass_e           cls_o,
    output logic [2:0]         funct3_o,
    output logic [6:0]         funct7_o,
    output logic               cls_valid_o
);

    logic [4:0] eff_opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    opclass_e   cls;

    // bits 1:0 of the opcode carry no information here
    assign eff_opcode = inst_i[`OPC_HI:`OPC_LO];
    assign funct3     = inst_i[`F3_HI:`F3_LO];
    assign funct7     = inst_i[`F7_HI:`F7_LO];

    // opcode classification
    always_comb begin
        case (eff_opcode)
            `EOPC_LUI: begin
                cls = LUI;
            end
            `EOPC_AUIPC: begin
                cls = AUIPC;
            end
            `EOPC_JAL: begin
                cls = JAL;
            end
            `EOPC_JALR: begin
                cls = JALR;
            end
            `EOPC_BRANCH: begin
                cls = BRANCH;
            end
            `EOPC_LOAD: begin
                cls = LOAD;
            end
            `EOPC_STORE: begin
                cls = STORE;
            end
            `EOPC_ALI: begin
                cls = ALI;
            end
            `EOPC_ALIW: begin
                cls = ALIW;
            end
            `EOPC_AL: begin
                cls = AL;
            end
            `EOPC_ALW: begin
                cls = ALW;
            end
            default: begin
                // system, fence, csr and anything unknown
                cls = NONE;
            end
        endcase
    end

    // valid flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cls_valid_o <= 1'b0;
        end else begin
            cls_valid_o <= inst_valid_i;
        end
    end

    // payload only loads with a valid instruction
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            cls_o    <= cls;
            funct3_o <= funct3;
            funct7_o <= funct7;
        end
    end

endmodule

// File: src/decode_pkg.sv
package decode_pkg;

    // opcode class, resolved in the first stage
    typedef enum logic [3:0] {
        NONE   = 4'd0,
        LUI    = 4'd1,
        AUIPC  = 4'd2,
        JAL    = 4'd3,
        JALR   = 4'd4,
        BRANCH = 4'd5,
        LOAD   = 4'd6,
        STORE  = 4'd7,
        ALI    = 4'd8,
        ALIW   = 4'd9,
        AL     = 4'd10,
        ALW    = 4'd11
    } opclass_e;

    // immediate format for the immediate generator
    typedef enum logic [2:0] {
        GEN_NONE = 3'd0,
        GEN_S    = 3'd3,
        GEN_U    = 3'd4,
        GEN_J    = 3'd5,
        GEN_I    = 3'd6,
        GEN_B    = 3'd7
    } gen_type_e;

    // alu operation
    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd3,
        ALU_SUB  = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_OR   = 3'd6,
        ALU_AND  = 3'd7
    } alu_op_e;

    // comparator mode, shared by branches and slt
    typedef enum logic [2:0] {
        CMP_NONE = 3'd0,
        CMP_EQ   = 3'd2,
        CMP_NE   = 3'd3,
        CMP_LT   = 3'd4,
        CMP_LTU  = 3'd5,
        CMP_GE   = 3'd6,
        CMP_GEU  = 3'd7
    } comp_type_e;

    // shifter mode, bit 1 marks the word forms
    typedef enum logic [2:0] {
        SH_NONE = 3'd0,
        SH_SLL  = 3'd1,
        SH_SLLW = 3'd3,
        SH_SRA  = 3'd4,
        SH_SRL  = 3'd5,
        SH_SRAW = 3'd6,
        SH_SRLW = 3'd7
    } shift_type_e;

    // load width and sign handling
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_H    = 3'd2,
        LD_W    = 3'd3,
        LD_D    = 3'd4,
        LD_BU   = 3'd5,
        LD_HU   = 3'd6,
        LD_WU   = 3'd7
    } load_type_e;

    // store width
    typedef enum logic [2:0] {
        ST_NONE = 3'd0,
        ST_B    = 3'd4,
        ST_H    = 3'd5,
        ST_W    = 3'd6,
        ST_D    = 3'd7
    } store_type_e;

endpackage

// File: src/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// raw instruction word
`define INST_W      32

// effective opcode is inst[6:2], bits 1:0 are always 11 for RV64I
`define OPC_HI      6
`define OPC_LO      2

// funct3 field
`define F3_HI       14
`define F3_LO       12

// funct7 field
`define F7_HI       31
`define F7_LO       25

// effective opcode values
`define EOPC_LUI    5'b01101
`define EOPC_AUIPC  5'b00101
`define EOPC_JAL    5'b11011
`define EOPC_JALR   5'b11001
`define EOPC_BRANCH 5'b11000
`define EOPC_LOAD   5'b00000
`define EOPC_STORE  5'b01000

// integer ops, immediate and register forms
`define EOPC_ALI    5'b00100
`define EOPC_ALIW   5'b00110
`define EOPC_AL     5'b01100
`define EOPC_ALW    5'b01110

`endif
